// File: ddr3_phy.f
+incdir+rtl
rtl/phy_pkg.sv
rtl/phy_frame_ctrl.sv
rtl/phy_slot_serializer.sv
rtl/phy_dq_driver.sv
rtl/phy_iserdes.sv
rtl/ddr3_phy.sv
sim/tb_ddr3_phy.sv

// File: rtl/ddr3_phy.sv
module ddr3_phy import phy_pkg::*; (
    input  logic                  i_controller_clk,
    input  logic                  i_ddr3_clk,
    input  logic                  i_reset,
    // Controller side
    input  ddr3_cmd_t [SLOTS-1:0] i_cmd_slots,     // Slot 0 goes out first
    input  wr_beats_t [SLOTS-1:0] i_wr_slots,
    input  logic                  i_dq_oe,
    input  logic                  i_toggle_dqs,
    input  logic [LANES-1:0]      i_bitslip,
    // DDR3 pins, bidirectional ones split
    input  logic [DQ_W-1:0]       i_ddr3_dq,
    input  logic [LANES-1:0]      i_ddr3_dqs,
    output ddr3_cmd_t             o_ddr3_cmd,
    output logic [DQ_W-1:0]       o_ddr3_dq,
    output logic [LANES-1:0]      o_ddr3_dq_oe,
    output logic [LANES-1:0]      o_ddr3_dqs,
    output logic [LANES-1:0]      o_ddr3_dqs_oe,
    output rd_frame_t             o_rd_frame
);

    // NOP-free idle, chip deselected and CKE low
    localparam ddr3_cmd_t CMD_DESELECT = '{
        cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
        odt: 1'b0, cke: 1'b0, reset_n: 1'b1, ba: '0, addr: '0
    };

    logic [1:0]           slot;
    logic                 frame_load;
    logic                 ref_bit;
    wr_slot_t [SLOTS-1:0] wr_slots;     // Write beats with their enables
    wr_slot_t             wr_slot;      // Slot now on DQ

    // Enables hold for the whole controller period
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            wr_slots[s] = '{dq_oe: i_dq_oe, dqs_toggle: i_toggle_dqs, beats: i_wr_slots[s]};
        end
    end

    phy_frame_ctrl frame_ctrl_i (
        .i_ddr3_clk   (i_ddr3_clk),
        .i_reset      (i_reset),
        .o_slot       (slot),
        .o_frame_load (frame_load),
        .o_ref_bit    (ref_bit)
    );

    phy_slot_serializer #(.slot_t(ddr3_cmd_t)) cmd_ser_i (
        .i_ddr3_clk   (i_ddr3_clk),
        .i_reset      (i_reset),
        .i_reset_slot (CMD_DESELECT),
        .i_frame_load (frame_load),
        .i_slot       (slot),
        .i_slots      (i_cmd_slots),
        .o_slot_data  (o_ddr3_cmd)
    );

    phy_slot_serializer #(.slot_t(wr_slot_t)) wr_ser_i (
        .i_ddr3_clk   (i_ddr3_clk),
        .i_reset      (i_reset),
        .i_reset_slot ('0),             // Bus released, DQS quiet
        .i_frame_load (frame_load),
        .i_slot       (slot),
        .i_slots      (wr_slots),
        .o_slot_data  (wr_slot)
    );

    phy_dq_driver dq_drv_i (
        .i_ddr3_clk    (i_ddr3_clk),
        .i_reset       (i_reset),
        .i_beats       (wr_slot.beats),
        .i_dq_oe       (wr_slot.dq_oe),
        .i_dqs_toggle  (wr_slot.dqs_toggle),
        .o_ddr3_dq     (o_ddr3_dq),
        .o_ddr3_dq_oe  (o_ddr3_dq_oe),
        .o_ddr3_dqs    (o_ddr3_dqs),
        .o_ddr3_dqs_oe (o_ddr3_dqs_oe)
    );

    phy_iserdes iserdes_i (
        .i_controller_clk (i_controller_clk),
        .i_ddr3_clk       (i_ddr3_clk),
        .i_reset          (i_reset),
        .i_slot           (slot),
        .i_ref_bit        (ref_bit),
        .i_ddr3_dq        (i_ddr3_dq),
        .i_ddr3_dqs       (i_ddr3_dqs),
        .i_bitslip        (i_bitslip),
        .o_frame          (o_rd_frame)
    );

    // Slot 3 closes on every controller edge, so frames line up with the controller
    a_frame_aligned: assert property (
        @(posedge i_controller_clk) disable iff (i_reset)
        frame_load
    ) else $error("frame strobe out of step with the controller clock");

endmodule

// File: rtl/phy_defines.svh
`ifndef PHY_DEFINES_SVH
`define PHY_DEFINES_SVH

// Byte lanes and pin widths
`define PHY_LANES       2
`define PHY_DQ_BITS     8       // DQ bits per lane
`define PHY_BA_BITS     3       // Bank address
`define PHY_ROW_BITS    14      // Row and column address pins

// Clock ratio and framing
`define PHY_SLOTS       4       // DDR3 clocks per controller clock
`define PHY_BEATS       8       // Two beats per DDR3 clock

// Reference frame looped through capture and bitslip
// Bit i holds beat i so beats 0 to 3 are low and 4 to 7 high
`define PHY_BITSLIP_REF 8'b1111_0000

`endif

// File: rtl/phy_dq_driver.sv
module phy_dq_driver import phy_pkg::*; (
    input  logic             i_ddr3_clk,
    input  logic             i_reset,
    input  wr_beats_t        i_beats,         // Beat pair of the current slot
    input  logic             i_dq_oe,
    input  logic             i_dqs_toggle,
    output logic [DQ_W-1:0]  o_ddr3_dq,
    output logic [LANES-1:0] o_ddr3_dq_oe,
    output logic [LANES-1:0] o_ddr3_dqs,
    output logic [LANES-1:0] o_ddr3_dqs_oe
);

    logic rise_q;           // Flips on every rising edge
    logic fall_q;           // Copies rise_q on the falling edge
    logic high_phase;       // DDR3 clock level
    logic postamble_q;      // Keeps DQS enabled one clock past the last toggle

    // Level rebuilt from edge registers
    // It changes together with the other flops, so capture sees a settled beat
    always_ff @(posedge i_ddr3_clk) begin
        if (i_reset) begin
            rise_q <= 1'b0;
        end else begin
            rise_q <= ~fall_q;
        end
    end

    always_ff @(negedge i_ddr3_clk) begin
        fall_q <= rise_q;
    end

    assign high_phase = rise_q ^ fall_q;    // Low throughout reset

    always_ff @(posedge i_ddr3_clk) begin
        if (i_reset) begin
            postamble_q <= 1'b0;
        end else begin
            postamble_q <= i_dqs_toggle;
        end
    end

    assign o_ddr3_dq     = high_phase ? i_beats.rise : i_beats.fall;
    assign o_ddr3_dq_oe  = {LANES{i_dq_oe}};
    assign o_ddr3_dqs    = {LANES{i_dqs_toggle & high_phase}};  // Follows the clock
    assign o_ddr3_dqs_oe = {LANES{i_dq_oe | i_dqs_toggle | postamble_q}};

    // DQS pulses stay inside the high phase, so a rising edge finds them low
    a_dqs_phase: assert property (
        @(posedge i_ddr3_clk) disable iff (i_reset)
        o_ddr3_dqs == '0
    ) else $error("DQS high at a rising clock edge");

endmodule

// File: rtl/phy_frame_ctrl.sv
module phy_frame_ctrl import phy_pkg::*; (
    input  logic       i_ddr3_clk,
    input  logic       i_reset,
    output logic [1:0] o_slot,          // DDR3 clock within the controller period
    output logic       o_frame_load,    // Last slot, serializers load on it
    output logic       o_ref_bit        // Reference value for this beat pair
);

    logic [1:0] slot_q;

    // Reset is released just after a controller edge
    // Slot 0 then starts on every controller edge
    always_ff @(posedge i_ddr3_clk) begin
        if (i_reset) begin
            slot_q <= 2'd0;
        end else begin
            slot_q <= slot_q + 2'd1;    // Wraps 3 to 0 on the controller edge
        end
    end

    assign o_slot       = slot_q;
    assign o_frame_load = (slot_q == 2'(SLOTS - 1));
    assign o_ref_bit    = BITSLIP_REF[{slot_q, 1'b0}];  // Even beat of the pair

endmodule

// File: rtl/phy_iserdes.sv
`include "phy_defines.svh"

module phy_iserdes import phy_pkg::*; (
    input  logic                  i_controller_clk,
    input  logic                  i_ddr3_clk,
    input  logic                  i_reset,
    input  logic [1:0]            i_slot,
    input  logic                  i_ref_bit,
    input  logic [DQ_W-1:0]       i_ddr3_dq,
    input  logic [`PHY_LANES-1:0] i_ddr3_dqs,
    input  logic [`PHY_LANES-1:0] i_bitslip,
    output rd_frame_t             o_frame
);

    // One sample of the pins plus the reference beat
    typedef struct packed {
        logic [`PHY_LANES-1:0][`PHY_DQ_BITS-1:0] dq;
        logic [`PHY_LANES-1:0]                   dqs;
        logic                                    ref_bit;
    } pin_smp_t;

    typedef struct packed {
        pin_smp_t rise;
        pin_smp_t fall;
    } smp_pair_t;

    pin_smp_t                   cur_smp;    // Pins as they stand at the edge
    pin_smp_t                   rise_q;     // High-phase beat
    smp_pair_t                  cur_pair;
    smp_pair_t [`PHY_SLOTS-2:0] asm_q;      // Pairs 0 to 2 of the open frame
    smp_pair_t [`PHY_SLOTS-1:0] frame_q;    // Last complete frame, DDR3 domain
    logic [`PHY_LANES-1:0][2:0] slip_q;     // Rotation per lane
    rd_frame_t                  rot_frame;

    assign cur_smp  = '{dq: i_ddr3_dq, dqs: i_ddr3_dqs, ref_bit: i_ref_bit};
    assign cur_pair = '{rise: rise_q, fall: cur_smp};

    always_ff @(negedge i_ddr3_clk) begin
        rise_q <= cur_smp;  // End of the high phase
    end

    // Rising edge closes the low phase of the slot still on i_slot
    always_ff @(posedge i_ddr3_clk) begin
        if (i_slot == 2'(`PHY_SLOTS - 1)) begin
            frame_q <= {cur_pair, asm_q};   // Frame strobe, pair 3 joins here
        end else begin
            asm_q[i_slot] <= cur_pair;
        end
    end

    always_ff @(posedge i_controller_clk) begin
        if (i_reset) begin
            slip_q <= '0;
        end else begin
            for (int l = 0; l < `PHY_LANES; l++) begin
                if (i_bitslip[l]) begin
                    slip_q[l] <= slip_q[l] + 3'd1;  // Modulo 8 by width
                end
            end
        end
    end

    // Rotate right within the frame, beat b takes beat b plus slip
    always_comb begin
        logic [2:0] src;
        pin_smp_t   beat;
        rot_frame = '0;
        for (int l = 0; l < `PHY_LANES; l++) begin
            for (int b = 0; b < `PHY_BEATS; b++) begin
                src  = 3'(b) + slip_q[l];
                beat = src[0] ? frame_q[src[2:1]].fall : frame_q[src[2:1]].rise;
                rot_frame.lane[l].data[b]        = beat.dq[l];
                rot_frame.lane[l].dqs[b]         = beat.dqs[l];
                rot_frame.lane[l].bitslip_ref[b] = beat.ref_bit;
            end
        end
    end

    // Controller edge after the frame closes
    always_ff @(posedge i_controller_clk) begin
        o_frame <= rot_frame;
    end

endmodule

// File: rtl/phy_pkg.sv
`include "phy_defines.svh"

package phy_pkg;

    localparam int LANES   = `PHY_LANES;
    localparam int DQ_BITS = `PHY_DQ_BITS;
    localparam int DQ_W    = LANES * DQ_BITS;   // All lanes of DQ
    localparam int SLOTS   = `PHY_SLOTS;
    localparam int BEATS   = `PHY_BEATS;
    localparam logic [BEATS-1:0] BITSLIP_REF = `PHY_BITSLIP_REF;

    // One command slot, one DDR3 clock on the pins
    typedef struct packed {
        logic                     cs_n;
        logic                     ras_n;
        logic                     cas_n;
        logic                     we_n;
        logic                     odt;
        logic                     cke;
        logic                     reset_n;
        logic [`PHY_BA_BITS-1:0]  ba;
        logic [`PHY_ROW_BITS-1:0] addr;
    } ddr3_cmd_t;

    // Write data for one DDR3 clock
    typedef struct packed {
        logic [DQ_W-1:0] rise;      // Even beat, driven in the high phase
        logic [DQ_W-1:0] fall;      // Odd beat
    } wr_beats_t;

    // Write slot with its enables, as carried by the serializer
    typedef struct packed {
        logic      dq_oe;
        logic      dqs_toggle;
        wr_beats_t beats;
    } wr_slot_t;

    typedef struct packed {
        logic [BEATS-1:0][DQ_BITS-1:0] data;    // Index is beat order
        logic [BEATS-1:0]              dqs;
        logic [BEATS-1:0]              bitslip_ref;
    } rd_lane_t;

    typedef struct packed {
        rd_lane_t [LANES-1:0] lane;
    } rd_frame_t;

endpackage

// File: rtl/phy_slot_serializer.sv
module phy_slot_serializer import phy_pkg::*; #(
    parameter type slot_t = ddr3_cmd_t
) (
    input  logic              i_ddr3_clk,
    input  logic              i_reset,
    input  slot_t             i_reset_slot,    // Idle slot held through reset
    input  logic              i_frame_load,
    input  logic [1:0]        i_slot,
    input  slot_t [SLOTS-1:0] i_slots,         // Controller domain, slot 0 goes out first
    output slot_t             o_slot_data
);

    slot_t [SLOTS-1:0] hold_q;      // Frame sampled at the controller edge
    slot_t [SLOTS-1:0] frame_q;     // Frame now on the pins

    // Load edge coincides with a controller edge
    always_ff @(posedge i_ddr3_clk) begin
        if (i_reset) begin
            hold_q  <= {SLOTS{i_reset_slot}};
            frame_q <= {SLOTS{i_reset_slot}};
        end else if (i_frame_load) begin
            hold_q  <= i_slots;
            frame_q <= hold_q;      // One controller period behind the inputs
        end
    end

    // Slot index steps once per DDR3 clock
    assign o_slot_data = frame_q[i_slot];

    // Pins stay defined once the frame pipeline has filled from reset
    a_slot_known: assert property (
        @(posedge i_ddr3_clk) disable iff (i_reset)
        !$isunknown(o_slot_data)
    ) else $error("serializer output went unknown");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f ddr3_phy.f --top-module tb_ddr3_phy \
    -o tb_ddr3_phy > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_ddr3_phy > sim.log 2>&1 || true
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1

// File: sim/tb_ddr3_phy.sv
module tb_ddr3_phy import phy_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam ddr3_cmd_t IDLE_CMD = '{
        cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
        odt: 1'b0, cke: 1'b0, reset_n: 1'b1, ba: '0, addr: '0
    };

    logic ctrl_clk = 1'b0;
    logic ddr3_clk = 1'b1;                  // Rises at 5 ns so every fourth edge meets ctrl_clk
    logic chk_clk  = 1'b0;                  // Mid-phase sampling of the DDR3 pins
    logic i_reset;
    ddr3_cmd_t [SLOTS-1:0] i_cmd_slots;
    wr_beats_t [SLOTS-1:0] i_wr_slots;
    logic i_dq_oe, i_toggle_dqs;
    logic [LANES-1:0] i_bitslip;
    logic [DQ_W-1:0] loop_dq, rnd_dq, o_ddr3_dq;
    logic [LANES-1:0] loop_dqs, rnd_dqs, o_ddr3_dq_oe, o_ddr3_dqs, o_ddr3_dqs_oe;
    ddr3_cmd_t o_ddr3_cmd;
    rd_frame_t o_rd_frame, exp_rd;

    // History of sampled inputs, indexed by controller edge
    ddr3_cmd_t [SLOTS-1:0] cmd_hist [64];
    wr_beats_t [SLOTS-1:0] wr_hist [64];
    logic oe_hist [64], tog_hist [64], vld_hist [64];
    int cyc = 0;                            // Number of the next controller edge
    logic [2:0] b_q = 3'd4;                 // Beat now on the pins
    logic [LANES-1:0][2:0] slip_exp = '0, slip_used = '0;
    logic [5:0] wi, ri;
    logic pins_vld, rd_vld, ref_vld, data_match, ref_match;
    ddr3_cmd_t exp_cmd;
    wr_beats_t exp_pair;
    logic [DQ_W-1:0] exp_dq;
    logic [LANES-1:0] exp_dqs;
    int err_cmd = 0, err_wr = 0, err_rd = 0;
    int idle_hits = 0, pin_hits = 0, rd_hits = 0, slip_hits = 0;

    always #10 ctrl_clk = ~ctrl_clk;
    always #2.5 ddr3_clk = ~ddr3_clk;
    always #1.25 chk_clk = ~chk_clk;

    ddr3_phy ddr3_phy_i (
        .*,
        .i_controller_clk (ctrl_clk),
        .i_ddr3_clk       (ddr3_clk),
        .i_ddr3_dq        (loop_dq),
        .i_ddr3_dqs       (loop_dqs)
    );

    // Loopback per lane, random bus when the lane is not driven
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            loop_dq[l*DQ_BITS +: DQ_BITS] = o_ddr3_dq_oe[l] ? o_ddr3_dq[l*DQ_BITS +: DQ_BITS]
                                                             : rnd_dq[l*DQ_BITS +: DQ_BITS];
            loop_dqs[l] = o_ddr3_dqs_oe[l] ? o_ddr3_dqs[l] : rnd_dqs[l];
        end
    end

    always @(posedge ctrl_clk) begin
        cmd_hist[cyc[5:0]] <= i_cmd_slots;
        wr_hist[cyc[5:0]]  <= i_wr_slots;
        oe_hist[cyc[5:0]]  <= i_dq_oe;
        tog_hist[cyc[5:0]] <= i_toggle_dqs;
        vld_hist[cyc[5:0]] <= !i_reset;
        cyc <= cyc + 1;
        for (int l = 0; l < LANES; l++) begin
            if (i_reset) slip_exp[l] <= 3'd0;
            else if (i_bitslip[l]) slip_exp[l] <= slip_exp[l] + 3'd1;  // Wraps at 8
        end
        slip_used <= slip_exp;              // Takes effect one read-out later
        if (rd_vld) rd_hits <= rd_hits + 1;
        if (rd_vld && slip_used != '0) slip_hits <= slip_hits + 1;
    end

    always @(posedge chk_clk) begin
        b_q <= b_q + 3'd1;
        if (!i_reset && pins_vld) pin_hits <= pin_hits + 1;
        if (!i_reset && cyc >= 2 && !pins_vld) idle_hits <= idle_hits + 1;
    end

    // Pins carry the frame sampled two edges back
    assign wi       = 6'(cyc - 2);
    assign pins_vld = (cyc >= 2) && vld_hist[wi];
    assign exp_cmd  = cmd_hist[wi][b_q[2:1]];
    assign exp_pair = wr_hist[wi][b_q[2:1]];
    assign exp_dq   = b_q[0] ? exp_pair.fall : exp_pair.rise;
    assign exp_dqs  = {LANES{tog_hist[wi] & ~b_q[0]}};    // High in the high phase only

    // Read-out seen at an edge left the DUT one edge earlier, written four edges back
    assign ri      = 6'(cyc - 4);
    assign ref_vld = (cyc >= 4) && vld_hist[ri];
    assign rd_vld  = ref_vld && oe_hist[ri];

    always_comb begin
        int j;
        wr_beats_t wb;
        data_match = 1'b1;
        ref_match  = 1'b1;
        for (int l = 0; l < LANES; l++) begin
            for (int b = 0; b < BEATS; b++) begin
                j  = (b + int'(slip_used[l])) % BEATS;    // Rotate right by the slip
                wb = wr_hist[ri][2'(j / 2)];
                exp_rd.lane[l].data[b] = (j % 2 == 1) ? wb.fall[l*DQ_BITS +: DQ_BITS]
                                                      : wb.rise[l*DQ_BITS +: DQ_BITS];
                exp_rd.lane[l].dqs[b]         = tog_hist[ri] && (j % 2 == 0);
                exp_rd.lane[l].bitslip_ref[b] = (j >= 4);  // Beats 4 to 7 high
            end
            data_match &= (o_rd_frame.lane[l].data == exp_rd.lane[l].data)
                       && (o_rd_frame.lane[l].dqs == exp_rd.lane[l].dqs);
            ref_match  &= (o_rd_frame.lane[l].bitslip_ref == exp_rd.lane[l].bitslip_ref);
        end
    end

    a_idle: assert property (@(posedge chk_clk) disable iff (i_reset)
        !(cyc >= 2 && !pins_vld)
        || (o_ddr3_cmd == IDLE_CMD && o_ddr3_dq_oe == '0 && o_ddr3_dqs_oe == '0))
    else begin
        err_cmd++;
        $display("FAIL %0t: idle pins cmd %h oe %b dqs_oe %b", $time, o_ddr3_cmd,
                 o_ddr3_dq_oe, o_ddr3_dqs_oe);
    end

    a_cmd: assert property (@(posedge chk_clk) disable iff (i_reset)
        !pins_vld || o_ddr3_cmd == exp_cmd)
    else begin
        err_cmd++;
        $display("FAIL %0t: cmd %h expected %h", $time, o_ddr3_cmd, exp_cmd);
    end

    a_wr: assert property (@(posedge chk_clk) disable iff (i_reset)
        !pins_vld || (o_ddr3_dq_oe == {LANES{oe_hist[wi]}} && o_ddr3_dqs == exp_dqs
                      && (!tog_hist[wi] || o_ddr3_dqs_oe == '1)    // Toggling DQS is driven
                      && (!oe_hist[wi] || o_ddr3_dq == exp_dq)))
    else begin
        err_wr++;
        $display("FAIL %0t: dq %h oe %b dqs %b dqs_oe %b expected %h %b %b", $time,
                 o_ddr3_dq, o_ddr3_dq_oe, o_ddr3_dqs, o_ddr3_dqs_oe, exp_dq, oe_hist[wi],
                 exp_dqs);
    end

    a_rd_data: assert property (@(posedge ctrl_clk) disable iff (i_reset)
        !rd_vld || data_match)
    else begin
        err_rd++;
        $display("FAIL %0t: read frame %h expected %h", $time, o_rd_frame, exp_rd);
    end

    a_rd_ref: assert property (@(posedge ctrl_clk) disable iff (i_reset)
        !ref_vld || ref_match)
    else begin
        err_rd++;
        $display("FAIL %0t: reference words wrong, slip %h", $time, slip_used);
    end

    function automatic int hit_count(input int which);
        case (which)
            0:       return idle_hits;
            1:       return pin_hits;
            2:       return rd_hits;
            default: return slip_hits;
        endcase
    endfunction

    // Step controller cycles until a check has been reached often enough
    task automatic wait_count(input int which, input int target, input int limit,
                              input string what);
        for (int n = 0; n < limit && hit_count(which) < target; n++) begin
            @(posedge ctrl_clk);
        end
        if (hit_count(which) < target) begin
            $display("timeout while waiting for %s", what);
            $display("sim failed");
            $finish;
        end
    endtask

    task automatic drive_frame(input logic oe, input logic tog, input logic [LANES-1:0] slip);
        @(posedge ctrl_clk);
        #2;
        for (int s = 0; s < SLOTS; s++) begin
            i_cmd_slots[s] = 24'($urandom);
            i_wr_slots[s]  = $urandom;
        end
        i_dq_oe      = oe;
        i_toggle_dqs = tog;
        i_bitslip    = slip;
        rnd_dq       = 16'($urandom);
        rnd_dqs      = 2'($urandom);
    endtask

    initial begin
        #50us;
        $display("simulation ran past its time limit");
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hbb35));
        i_reset      = 1'b1;
        i_cmd_slots  = '0;
        i_wr_slots   = '0;
        i_dq_oe      = 1'b0;
        i_toggle_dqs = 1'b0;
        i_bitslip    = '0;
        rnd_dq       = '0;
        rnd_dqs      = '0;
        repeat (2) @(posedge ctrl_clk);
        #2 i_reset = 1'b0;
        wait_count(0, 4, 10, "the idle window after reset");
        for (int i = 0; i < 40; i++) begin
            drive_frame(($urandom % 4) != 0, 1'($urandom), '0);
        end
        wait_count(2, 10, 20, "loopback read-outs");
        for (int k = 0; k < 3; k++) begin         // Lane 0 only, lane 1 stays put
            drive_frame(1'b1, 1'b1, 2'b01);
            repeat (5) drive_frame(1'b1, 1'($urandom), '0);
        end
        for (int i = 0; i < 20; i++) begin
            drive_frame(1'b1, 1'($urandom), 2'($urandom));
        end
        repeat (6) drive_frame(1'b1, 1'b1, '0);
        wait_count(3, 20, 20, "read-outs with bitslip");
        $display("errors: cmd %0d, write %0d, read %0d, checks pins %0d reads %0d",
                 err_cmd, err_wr, err_rd, pin_hits, rd_hits);
        if (err_cmd + err_wr + err_rd == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
